/* logic/ppb_config.svh */
// sizing macros for the ping-pong line buffer; include wherever a width or depth is needed
`ifndef PPB_CONFIG_SVH
`define PPB_CONFIG_SVH

//////////////////////////////////////////////////
// datapath sizes
//////////////////////////////////////////////////
`define PPB_DATA_W        8     // one pixel per byte
`define PPB_ADDR_W        10    // 1024 words per bank
`define PPB_BANK_WORDS    1024  // words in each sram bank

// frame depth loaded at reset
`define PPB_DEPTH_DEFAULT 768

`endif

/* logic/ppb_pkg.sv */
// shared types for the ping-pong line buffer; imported by every design module
`include "ppb_config.svh"

package ppb_pkg;

  //////////////////////////////////////////////////
  // vector types
  //////////////////////////////////////////////////
  typedef logic [`PPB_DATA_W-1:0] pix_t;     // one pixel
  typedef logic [`PPB_ADDR_W-1:0] addr_t;    // bank address or fill count

  // one extra bit so a full 1024 word frame fits
  typedef logic [`PPB_ADDR_W:0]   depth_t;

  typedef logic [15:0]            frame_cnt_t;  // completed frames, wraps

  //////////////////////////////////////////////////
  // fill controller state
  //////////////////////////////////////////////////
  typedef enum logic {
    FILL_BANK0 = 1'b0,  // bank0 fills, bank1 serves reads
    FILL_BANK1 = 1'b1   // bank1 fills, bank0 serves reads
  } fill_state_t;

endpackage

/* logic/bank_port_if.sv */
// port bundle of one single-port sram bank; router drives it, the bank answers
`timescale 1ns/1ps

interface bank_port_if;
  import ppb_pkg::*;

  addr_t addr;   // word address
  pix_t  wdata;  // write data
  logic  we;     // write enable
  logic  cs;     // chip select
  pix_t  rdata;  // registered read data

  // controller side
  modport ctrl (
    output addr,
    output wdata,
    output we,
    output cs,
    input  rdata
  );

  // memory side
  modport mem (
    input  addr,
    input  wdata,
    input  we,
    input  cs,
    output rdata
  );

endinterface

/* logic/sram_bank.sv */
// single-port synchronous ram with registered read; one instance per ping-pong bank
`timescale 1ns/1ps
`include "ppb_config.svh"

module sram_bank (
  input  logic      i_clk_output,
  input  logic      i_rst_n,
  bank_port_if.mem  port
);
  import ppb_pkg::*;

  pix_t mem_array [0:`PPB_BANK_WORDS-1];  // pixel storage

  //////////////////////////////////////////////////
  // write port
  //////////////////////////////////////////////////
  always_ff @(posedge i_clk_output) begin
    if (port.cs && port.we) begin
      mem_array[port.addr] <= port.wdata;  // store at edge
    end
  end

  //////////////////////////////////////////////////
  // read port
  //////////////////////////////////////////////////
  always_ff @(posedge i_clk_output or negedge i_rst_n) begin
    if (!i_rst_n) begin
      port.rdata <= '0;
    end else if (port.cs && !port.we) begin
      port.rdata <= mem_array[port.addr];  // one cycle latency
    end
    // deselected or writing keeps the last word
  end

  // selected bank must see a clean address from the router
  a_addr_known : assert property (
    @(posedge i_clk_output) disable iff (!i_rst_n)
    port.cs |-> !$isunknown(port.addr)
  ) else $error("sram_bank: unknown address while selected");

endmodule

/* logic/ppb_cfg_regs.sv */
// runtime configuration of frame depth and enable, plus the completed-frame counter
`timescale 1ns/1ps
`include "ppb_config.svh"

module ppb_cfg_regs (
  input  logic                i_clk_output,
  input  logic                i_rst_n,
  input  logic                i_cfg_we,       // single cycle write strobe
  input  logic                i_cfg_sel,      // 0 depth, 1 enable
  input  ppb_pkg::depth_t     i_cfg_wdata,
  input  logic                i_frame_done,   // pulse per completed frame
  output ppb_pkg::depth_t     o_depth,
  output logic                o_enable,
  output ppb_pkg::frame_cnt_t o_frame_count
);
  import ppb_pkg::*;

  logic depth_ok;  // requested depth fits a bank

  // depth must be 1..bank size
  assign depth_ok = (i_cfg_wdata != '0) &&
                    (i_cfg_wdata <= depth_t'(`PPB_BANK_WORDS));

  //////////////////////////////////////////////////
  // depth and enable registers
  //////////////////////////////////////////////////
  always_ff @(posedge i_clk_output or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_depth  <= depth_t'(`PPB_DEPTH_DEFAULT);
      o_enable <= 1'b1;                        // buffer runs out of reset
    end else if (i_cfg_we) begin
      if (!i_cfg_sel) begin
        if (depth_ok) begin
          o_depth <= i_cfg_wdata;              // out of range dropped
        end
      end else begin
        o_enable <= i_cfg_wdata[0];            // bit 0 only
      end
    end
  end

  //////////////////////////////////////////////////
  // frame counter
  //////////////////////////////////////////////////
  always_ff @(posedge i_clk_output or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_frame_count <= '0;
    end else if (i_frame_done) begin
      o_frame_count <= o_frame_count + 1'b1;   // wraps at top
    end
  end

  // fill controller relies on a nonzero depth for its last-word compare
  a_depth_nonzero : assert property (
    @(posedge i_clk_output) disable iff (!i_rst_n)
    o_depth != '0
  ) else $error("ppb_cfg_regs: frame depth reached zero");

endmodule

/* logic/fill_ctrl.sv */
// fill side control; follows the switch level, counts writes and pulses ready per frame
`timescale 1ns/1ps
`include "ppb_config.svh"

module fill_ctrl (
  input  logic            i_clk_output,
  input  logic            i_rst_n,
  input  logic            i_switch_pingpong,  // level, names the fill bank
  input  ppb_pkg::pix_t   i_data_din,
  input  logic            i_data_din_vld,
  input  ppb_pkg::depth_t i_depth,            // from config block
  input  logic            i_enable,
  output logic            o_fill_bank,        // bank written at this edge
  output logic            o_wr_en,
  output ppb_pkg::addr_t  o_wr_addr,
  output ppb_pkg::pix_t   o_wr_data,
  output logic            o_pl_buffer_ready,
  output logic            o_state_change,
  output logic            o_frame_done
);
  import ppb_pkg::*;

  fill_state_t state_q;    // current fill bank
  fill_state_t state_nxt;
  depth_t      cnt_q;      // words written this frame
  depth_t      cnt_cur;    // count seen by this edge
  depth_t      cnt_nxt;
  depth_t      depth_q;    // depth latched for this frame
  depth_t      depth_cur;
  logic        flip;       // switch level differs from state
  logic        last_wr;    // final word of the frame
  logic        ready_q;

  //////////////////////////////////////////////////
  // fsm next state
  //////////////////////////////////////////////////
  always_comb begin
    case (i_switch_pingpong)
      1'b1:    state_nxt = FILL_BANK1;
      default: state_nxt = FILL_BANK0;
    endcase
  end

  assign flip      = (state_nxt != state_q);
  assign cnt_cur   = flip ? '0 : cnt_q;           // new frame starts at 0
  assign depth_cur = flip ? i_depth : depth_q;    // depth picked up on switch

  //////////////////////////////////////////////////
  // write request
  //////////////////////////////////////////////////
  assign o_wr_en     = i_data_din_vld && i_enable && (cnt_cur < depth_cur);
  assign o_wr_addr   = addr_t'(cnt_cur);          // count below 1024 when writing
  assign o_wr_data   = i_data_din;
  assign o_fill_bank = (state_nxt == FILL_BANK1); // same edge write lands in new bank

  assign last_wr = o_wr_en && (cnt_cur == depth_cur - 1'b1);
  assign cnt_nxt = o_wr_en ? cnt_cur + 1'b1 : cnt_cur;  // extra bytes dropped

  //////////////////////////////////////////////////
  // state, counter and pulses
  //////////////////////////////////////////////////
  always_ff @(posedge i_clk_output or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q        <= FILL_BANK0;
      cnt_q          <= '0;
      depth_q        <= depth_t'(`PPB_DEPTH_DEFAULT);
      ready_q        <= 1'b0;
      o_state_change <= 1'b0;
    end else begin
      state_q        <= state_nxt;
      cnt_q          <= cnt_nxt;
      depth_q        <= depth_cur;
      ready_q        <= last_wr;   // one cycle after last word
      o_state_change <= flip;      // one cycle after the flip
    end
  end

  assign o_pl_buffer_ready = ready_q;
  assign o_frame_done      = ready_q;  // frame counter follows ready

  // count stops at the latched depth across frames
  a_cnt_in_range : assert property (
    @(posedge i_clk_output) disable iff (!i_rst_n)
    cnt_q <= depth_q
  ) else $error("fill_ctrl: fill count past latched depth");

  // disabled buffer writes nothing, so the count only moves on a switch
  a_cnt_hold_disabled : assert property (
    @(posedge i_clk_output) disable iff (!i_rst_n)
    (!i_enable && !flip) |=> $stable(cnt_q)
  ) else $error("fill_ctrl: fill count moved while disabled");

endmodule

/* logic/bank_router.sv */
// routes fill writes and reader addresses to the two banks and registers the read data
`timescale 1ns/1ps

module bank_router (
  input  logic           i_clk_output,
  input  logic           i_rst_n,
  input  logic           i_fill_bank,   // bank that takes writes
  input  logic           i_wr_en,
  input  ppb_pkg::addr_t i_wr_addr,
  input  ppb_pkg::pix_t  i_wr_data,
  input  ppb_pkg::addr_t i_conv_addr,   // reader address
  input  logic           i_enable,
  bank_port_if.ctrl      bank0,
  bank_port_if.ctrl      bank1,
  output ppb_pkg::pix_t  o_conv_dout
);
  import ppb_pkg::*;

  logic rd_bank_q;  // bank read at the last edge
  logic rd_vld_q;   // a read really happened then

  //////////////////////////////////////////////////
  // bank steering
  //////////////////////////////////////////////////
  always_comb begin
    bank0.cs    = i_enable;   // both banks idle when disabled
    bank1.cs    = i_enable;
    bank0.wdata = i_wr_data;
    bank1.wdata = i_wr_data;
    if (i_fill_bank) begin
      bank1.addr = i_wr_addr;   // bank1 fills
      bank1.we   = i_wr_en;
      bank0.addr = i_conv_addr; // bank0 serves reads
      bank0.we   = 1'b0;
    end else begin
      bank0.addr = i_wr_addr;   // bank0 fills
      bank0.we   = i_wr_en;
      bank1.addr = i_conv_addr; // bank1 serves reads
      bank1.we   = 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // read pipeline
  //////////////////////////////////////////////////
  always_ff @(posedge i_clk_output or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rd_bank_q   <= 1'b1;      // bank1 reads out of reset
      rd_vld_q    <= 1'b0;
      o_conv_dout <= '0;
    end else begin
      rd_bank_q <= ~i_fill_bank;  // travels with the ram read
      rd_vld_q  <= i_enable;
      if (rd_vld_q) begin
        o_conv_dout <= rd_bank_q ? bank1.rdata : bank0.rdata;
      end
      // held while disabled
    end
  end

  // fill controller and steering keep exactly one bank writable
  a_one_writer : assert property (
    @(posedge i_clk_output) disable iff (!i_rst_n)
    !(bank0.we && bank1.we)
  ) else $error("bank_router: both banks written in one cycle");

endmodule

/* logic/pingpong_buffer_top.sv */
// ping-pong line buffer top; byte stream fills one bank while the conv engine reads the other
`timescale 1ns/1ps

module pingpong_buffer_top (
  input  logic                i_clk_output,
  input  logic                i_rst_n,
  input  logic                i_switch_pingpong,  // selects the fill bank
  input  ppb_pkg::pix_t       i_data_din,
  input  logic                i_data_din_vld,
  input  ppb_pkg::addr_t      i_conv_addr,
  input  logic                i_cfg_we,
  input  logic                i_cfg_sel,
  input  ppb_pkg::depth_t     i_cfg_wdata,
  output logic                o_pl_buffer_ready,
  output ppb_pkg::pix_t       o_conv_dout,
  output logic                o_state_change,
  output ppb_pkg::frame_cnt_t o_frame_count
);
  import ppb_pkg::*;

  depth_t depth;       // configured frame depth
  logic   enable;      // chip enable
  logic   frame_done;  // per frame pulse to counter
  logic   fill_bank;
  logic   wr_en;
  addr_t  wr_addr;
  pix_t   wr_data;

  bank_port_if bank0 ();  // bank0 port
  bank_port_if bank1 ();  // bank1 port

  //////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////
  ppb_cfg_regs u_cfg (
    .i_clk_output  (i_clk_output),
    .i_rst_n       (i_rst_n),
    .i_cfg_we      (i_cfg_we),
    .i_cfg_sel     (i_cfg_sel),
    .i_cfg_wdata   (i_cfg_wdata),
    .i_frame_done  (frame_done),
    .o_depth       (depth),
    .o_enable      (enable),
    .o_frame_count (o_frame_count)
  );

  fill_ctrl u_fill (
    .i_clk_output      (i_clk_output),
    .i_rst_n           (i_rst_n),
    .i_switch_pingpong (i_switch_pingpong),
    .i_data_din        (i_data_din),
    .i_data_din_vld    (i_data_din_vld),
    .i_depth           (depth),
    .i_enable          (enable),
    .o_fill_bank       (fill_bank),
    .o_wr_en           (wr_en),
    .o_wr_addr         (wr_addr),
    .o_wr_data         (wr_data),
    .o_pl_buffer_ready (o_pl_buffer_ready),
    .o_state_change    (o_state_change),
    .o_frame_done      (frame_done)
  );

  //////////////////////////////////////////////////
  // datapath
  //////////////////////////////////////////////////
  bank_router u_router (
    .i_clk_output (i_clk_output),
    .i_rst_n      (i_rst_n),
    .i_fill_bank  (fill_bank),
    .i_wr_en      (wr_en),
    .i_wr_addr    (wr_addr),
    .i_wr_data    (wr_data),
    .i_conv_addr  (i_conv_addr),
    .i_enable     (enable),
    .bank0        (bank0.ctrl),
    .bank1        (bank1.ctrl),
    .o_conv_dout  (o_conv_dout)
  );

  sram_bank u_bank0 (
    .i_clk_output (i_clk_output),
    .i_rst_n      (i_rst_n),
    .port         (bank0.mem)
  );

  sram_bank u_bank1 (
    .i_clk_output (i_clk_output),
    .i_rst_n      (i_rst_n),
    .port         (bank1.mem)
  );

endmodule

/* dv/tb_pingpong_buffer.sv */
// self-checking testbench for the ping-pong line buffer; random stream against a bank model
`timescale 1ns/1ps
`include "ppb_config.svh"

module tb_pingpong_buffer;
  import ppb_pkg::*;

  localparam int CLK_NS    = 100;
  localparam int RST_CYC   = 8;
  localparam int FILL_MAX  = 2000;  // bound on the first fill
  localparam int RD_CYC    = 300;
  localparam int ALT_SEGS  = 8;     // switches in the alternation phase
  localparam int SEG_MAX   = 150;
  localparam int DEPTH_CYC = 160;
  localparam int EN_CYC    = 260;
  localparam int TOTAL_CYC = RST_CYC + FILL_MAX + RD_CYC + ALT_SEGS * SEG_MAX
                             + DEPTH_CYC + EN_CYC;

  logic clk, rst_n, switch_pp, din_vld, cfg_we, cfg_sel;
  pix_t       din;
  addr_t      conv_addr;
  depth_t     cfg_wdata;
  logic       ready, state_change;
  pix_t       conv_dout;
  frame_cnt_t frame_count;

  // model state after the last modeled edge
  pix_t       bank_m [0:1][0:`PPB_BANK_WORDS-1];  // unwritten words stay x like the rams
  logic       m_fill, m_enable, m_ready, m_sc, m_rd_vld;
  depth_t     m_cnt, m_depth_lat, m_depth_reg;
  frame_cnt_t m_frames;
  pix_t       m_rd_val, m_dout;

  int mis_cnt, fail_cnt, ready_cnt, sc_cnt, mark;
  int addr_span;  // reader address range
  frame_cnt_t frames_start;

  pingpong_buffer_top UUT (
    .i_clk_output      (clk),
    .i_rst_n           (rst_n),
    .i_switch_pingpong (switch_pp),
    .i_data_din        (din),
    .i_data_din_vld    (din_vld),
    .i_conv_addr       (conv_addr),
    .i_cfg_we          (cfg_we),
    .i_cfg_sel         (cfg_sel),
    .i_cfg_wdata       (cfg_wdata),
    .o_pl_buffer_ready (ready),
    .o_conv_dout       (conv_dout),
    .o_state_change    (state_change),
    .o_frame_count     (frame_count)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////
  task automatic check_pix(input string name, input pix_t got, input pix_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      mis_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
      mis_cnt++;
    end
  endtask

  task automatic check_frames(input string name, input frame_cnt_t got, input frame_cnt_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
      mis_cnt++;
    end
  endtask

  //////////////////////////////////////////////////
  // reference model, one rising edge
  //////////////////////////////////////////////////
  task automatic model_edge();
    logic   flip;
    logic   wr;
    logic   last;
    depth_t cnt;
    depth_t dep;
    flip = (switch_pp != m_fill);              // level names the fill bank
    cnt  = flip ? depth_t'(0) : m_cnt;         // new frame at address 0
    dep  = flip ? m_depth_reg : m_depth_lat;   // depth taken at the switch
    wr   = din_vld && m_enable && (cnt < dep);
    last = wr && (cnt == dep - 1'b1);
    if (m_ready) m_frames = m_frames + 1'b1;   // counter trails the pulse
    if (m_rd_vld) m_dout = m_rd_val;           // mux register takes last ram word
    m_rd_vld = m_enable;
    if (m_enable) m_rd_val = bank_m[!switch_pp][conv_addr];  // read side bank
    if (wr) begin
      bank_m[switch_pp][cnt[`PPB_ADDR_W-1:0]] = din;
      cnt = cnt + 1'b1;
    end
    m_fill      = switch_pp;
    m_cnt       = cnt;
    m_depth_lat = dep;
    m_ready     = last;
    m_sc        = flip;
    if (cfg_we && !cfg_sel && cfg_wdata != 0 && cfg_wdata <= `PPB_BANK_WORDS) begin
      m_depth_reg = cfg_wdata;                 // zero or oversize ignored
    end else if (cfg_we && cfg_sel) begin
      m_enable = cfg_wdata[0];
    end
  endtask

  // model and check just after each edge
  task automatic advance_edge();
    @(posedge clk);
    #1;
    model_edge();
    check_pix("o_conv_dout", conv_dout, m_dout);
    check_bit("o_pl_buffer_ready", ready, m_ready);
    check_bit("o_state_change", state_change, m_sc);
    check_frames("o_frame_count", frame_count, m_frames);
    ready_cnt += ready;
    sc_cnt    += state_change;
    #(10 - 1);
  endtask

  task automatic drive_stream(input int vld_pct);
    din_vld   = ($urandom_range(99) < vld_pct);
    din       = pix_t'($urandom);
    conv_addr = addr_t'($urandom_range(addr_span - 1));  // reader hits every cycle
  endtask

  task automatic run_stream(input int cycles, input int vld_pct);
    repeat (cycles) begin
      drive_stream(vld_pct);
      advance_edge();
    end
  endtask

  task automatic cfg_write(input logic sel, input depth_t val);
    cfg_we    = 1'b1;
    cfg_sel   = sel;
    cfg_wdata = val;
    din_vld   = 1'b0;
    advance_edge();
    cfg_we    = 1'b0;                          // single cycle strobe
  endtask

  task automatic expect_true(input logic ok, input string what);
    if (!ok) begin
      $display("Failure at %0t ns: %s", $time, what);
      fail_cnt++;
    end
  endtask

  //////////////////////////////////////////////////
  // watchdog
  //////////////////////////////////////////////////
  initial begin
    #((TOTAL_CYC + 100) * CLK_NS);
    $display("Watchdog expired: the test sequence did not finish in time");
    $display("Simulation FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////
  initial begin
    void'($urandom(32'h25d35ae5));
    rst_n       = 1'b0;
    switch_pp   = 1'b0;
    din_vld     = 1'b0;
    din         = '0;
    conv_addr   = '0;
    cfg_we      = 1'b0;
    cfg_sel     = 1'b0;
    cfg_wdata   = '0;
    addr_span   = `PPB_BANK_WORDS;
    m_fill      = 1'b0;
    m_enable    = 1'b1;
    m_ready     = 1'b0;
    m_sc        = 1'b0;
    m_rd_vld    = 1'b0;
    m_cnt       = '0;
    m_depth_lat = `PPB_DEPTH_DEFAULT;
    m_depth_reg = `PPB_DEPTH_DEFAULT;
    m_frames    = '0;
    m_rd_val    = '0;
    m_dout      = '0;
    mis_cnt     = 0;
    fail_cnt    = 0;
    ready_cnt   = 0;
    sc_cnt      = 0;
    repeat (RST_CYC) @(posedge clk);
    #10 rst_n = 1'b1;

    // reset state
    check_bit("o_pl_buffer_ready", ready, 1'b0);
    check_bit("o_state_change", state_change, 1'b0);
    check_pix("o_conv_dout", conv_dout, '0);
    check_frames("o_frame_count", frame_count, '0);

    // fill bank 0, then read it back from the other side
    mark = 0;
    while (m_cnt < m_depth_lat && mark < FILL_MAX) begin
      drive_stream($urandom_range(40, 95));
      advance_edge();
      mark++;
    end
    expect_true(m_cnt == m_depth_lat, "bank 0 did not fill within the cycle budget");
    expect_true(ready_cnt == 1, "no single ready pulse after the first frame");
    switch_pp = 1'b1;
    run_stream(RD_CYC, 75);

    // alternation with flips at random points
    mark = sc_cnt;
    for (int s = 0; s < ALT_SEGS; s++) begin
      run_stream($urandom_range(20, SEG_MAX), 75);
      switch_pp = ~switch_pp;
    end
    run_stream(2, 75);
    expect_true(sc_cnt - mark == ALT_SEGS, "state change pulses do not match the switches");

    // depth 16 waits for the next switch
    addr_span = 64;                            // reads stay near the short frames
    cfg_write(1'b0, depth_t'(16));
    run_stream(40, 100);
    run_stream(3, 0);
    switch_pp    = ~switch_pp;
    frames_start = m_frames;
    run_stream(60, 100);                       // bytes past 16 are dropped
    check_frames("o_frame_count", frame_count, frames_start + 1'b1);
    cfg_write(1'b0, depth_t'(0));              // ignored
    switch_pp    = ~switch_pp;
    frames_start = m_frames;
    run_stream(40, 100);
    check_frames("o_frame_count", frame_count, frames_start + 1'b1);

    // enable off, then back on
    cfg_write(1'b1, depth_t'(0));
    mark = ready_cnt;
    run_stream(50, 90);
    switch_pp = ~switch_pp;
    run_stream(50, 90);
    expect_true(ready_cnt == mark, "ready pulsed while the buffer was disabled");
    cfg_write(1'b1, depth_t'(1));
    switch_pp = ~switch_pp;
    run_stream(100, 90);
    switch_pp = ~switch_pp;
    run_stream(40, 0);                         // read back the resumed frame
    check_frames("o_frame_count", frame_count, m_frames);

    $display("errors: %0d mismatches, %0d other failures", mis_cnt, fail_cnt);
    if (mis_cnt == 0 && fail_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+logic
logic/ppb_pkg.sv
logic/bank_port_if.sv
logic/sram_bank.sv
logic/ppb_cfg_regs.sv
logic/fill_ctrl.sv
logic/bank_router.sv
logic/pingpong_buffer_top.sv
dv/tb_pingpong_buffer.sv
